// ==== rv_decode_cluster.f ====
+incdir+.
rv_decode_pkg.sv
inst_dispatch.sv
inst_decode_lane.sv
decode_collect.sv
rv_decode_cluster.sv
tb_rv_decode_cluster.sv

// ==== Bender.yml ====
package:
  name: rv_decode_cluster

sources:
  - include_dirs:
      - .
    files:
      - rv_decode_pkg.sv
      - inst_dispatch.sv
      - inst_decode_lane.sv
      - decode_collect.sv
      - rv_decode_cluster.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_decode_cluster.sv

// ==== tb_rv_decode_model.svh ====
`ifndef TB_RV_DECODE_MODEL_SVH
`define TB_RV_DECODE_MODEL_SVH

// maximal length taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// expected decode, worked out from opcode, funct3 and funct7 fields
function automatic dec_result_t rv_model_decode(logic [31:0] w);
    dec_result_t r;
    dec_ctrl_t   c;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        legal;
    f3        = w[14:12];
    f7        = w[31:25];
    legal     = 1'b1;
    c         = '0;
    c.b_sel   = b_imm;  // most kinds: reg op imm, writes rd
    c.reg_wen = 1'b1;
    c.op.alu  = alu_add;
    case (w[6:0])
        7'b0110111: begin
            c.imm_sel = imm_u;
            c.a_sel   = a_zero;
        end
        7'b0010111: begin
            c.imm_sel = imm_u;
            c.a_sel   = a_pc;
        end
        7'b1101111: begin
            c.imm_sel = imm_j;
            c.a_sel   = a_pc;
            c.pc_sel  = pc_alu;
            c.wb_sel  = wb_pc4;
        end
        7'b1100111: begin
            c.imm_sel = imm_i;
            c.pc_sel  = pc_alu;
            c.wb_sel  = wb_pc4;
            legal     = (f3 == 3'd0);
        end
        7'b0100011: begin
            c.imm_sel = imm_s;
            c.reg_wen = 1'b0;
            c.mem_wen = 1'b1;
            legal     = (f3 == 3'd0 || f3 == 3'd2 || f3 == 3'd3);  // sb sw sd
        end
        7'b0000011: begin
            c.imm_sel = imm_i;
            c.wb_sel  = wb_mem;
            c.mem_ren = 1'b1;
            legal     = (f3 == 3'd2 || f3 == 3'd3 || f3 == 3'd4);  // lw ld lbu
        end
        7'b0010011: begin
            c.imm_sel = imm_i;
            case (f3)
                3'd0: c.op.alu = alu_add;
                3'd3: c.op.alu = alu_sltu;
                3'd4: c.op.alu = alu_xor;
                3'd7: c.op.alu = alu_and;
                3'd1: begin
                    c.op.alu = alu_sll;
                    legal    = (w[31:26] == 6'd0);
                end
                3'd5: begin
                    c.op.alu = w[30] ? alu_sra : alu_srl;
                    legal    = !w[31] && (w[29:26] == 4'd0);
                end
                default: legal = 1'b0;
            endcase
        end
        7'b0011011: begin
            c.imm_sel = imm_i;
            c.op.alu  = alu_addw;
            legal     = (f3 == 3'd0);
        end
        7'b0110011, 7'b0111011: begin
            c.b_sel = b_reg;
            // bit 3 splits the 64 bit and the word forms
            case ({w[3], f7, f3})
                {1'b0, 7'h00, 3'd0}: c.op.alu = alu_add;
                {1'b0, 7'h20, 3'd0}: c.op.alu = alu_sub;
                {1'b0, 7'h00, 3'd7}: c.op.alu = alu_and;
                {1'b0, 7'h00, 3'd6}: c.op.alu = alu_or;
                {1'b0, 7'h00, 3'd3}: c.op.alu = alu_sltu;
                {1'b1, 7'h00, 3'd0}: c.op.alu = alu_addw;
                {1'b1, 7'h00, 3'd1}: c.op.alu = alu_sllw;
                {1'b1, 7'h01, 3'd0}: c.op.alu = alu_mulw;
                {1'b1, 7'h01, 3'd4}: c.op.alu = alu_divw;
                {1'b1, 7'h01, 3'd6}: c.op.alu = alu_remw;
                default: legal = 1'b0;
            endcase
        end
        7'b1100011: begin
            c.imm_sel = imm_b;
            c.b_sel   = b_reg;
            c.reg_wen = 1'b0;
            c.pc_sel  = pc_branch;
            case (f3)
                3'd0: c.op.br = br_beq;
                3'd1: c.op.br = br_bne;
                3'd5: c.op.br = br_bge;
                default: legal = 1'b0;
            endcase
        end
        7'b1110011: begin
            c     = '0;
            legal = (w == 32'h0010_0073);  // ebreak only
        end
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        c         = '0;
        c.illegal = 1'b1;
    end
    c.func3 = f3;
    c.rd    = w[11:7];
    case (c.imm_sel)
        imm_i:   imm = {{20{w[31]}}, w[31:20]};
        imm_s:   imm = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b:   imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u:   imm = {w[31:12], 12'h000};
        imm_j:   imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        default: imm = '0;
    endcase
    r.ctrl = c;
    r.imm  = {{32{imm[31]}}, imm};
    return r;
endfunction

task automatic check_ctrl(string name, logic [31:0] got, dec_ctrl_t exp);
    if (got !== 32'(exp)) begin
        $display("[FAIL] %s got %h expected %h", name, got, 32'(exp));
        abort_run();
    end
endtask

task automatic check_imm(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_count(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_resp(string name, logic [1:0] got, logic [1:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

`endif

// ==== tb_rv_decode_cluster.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module tb_rv_decode_cluster;
    import rv_decode_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NL         = `RV_NUM_LANES;
    localparam int DEPTH      = `RV_FIFO_DEPTH;
    localparam int BATCH      = 6;  // more than the lane count
    localparam int N_LEGAL    = 60;
    localparam int N_ILLEGAL  = 6;
    localparam int N_INST     = N_LEGAL + N_ILLEGAL + NL + DEPTH + 8;

    typedef struct packed {
        logic [3:0]  addr;
        logic [1:0]  resp;
        logic [31:0] data;
    } rd_exp_t;

    logic        clk_i     = 1'b0;
    logic        arst_n_i  = 1'b0;
    logic        awvalid_i = 1'b0;
    logic [3:0]  awaddr_i  = '0;
    logic        wvalid_i  = 1'b0;
    logic [31:0] wdata_i   = '0;
    logic [3:0]  wstrb_i   = '0;
    logic        bready_i  = 1'b1;
    logic        arvalid_i = 1'b0;
    logic [3:0]  araddr_i  = '0;
    logic        rready_i  = 1'b1;
    logic        awready_o;
    logic        wready_o;
    logic        bvalid_o;
    logic [1:0]  bresp_o;
    logic        arready_o;
    logic        rvalid_o;
    logic [31:0] rdata_o;
    logic [1:0]  rresp_o;

    logic [31:0] lfsr_state = 32'hcfc9;
    logic        late_done  = 1'b0;
    dec_result_t exp_q[$];    // written and not yet popped by a CTRL read
    rd_exp_t     rd_exp_q[$];
    logic [1:0]  b_exp_q[$];

    rv_decode_cluster rv_decode_cluster_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    `include "tb_rv_decode_model.svh"

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r          = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // random fields under the fixed opcode and funct bits of the kind
    function automatic logic [31:0] make_inst(int kind);
        logic [31:0] w;
        w = take_bits(32);
        case (kind)
            0:  w[6:0] = 7'b0010111;                                         // auipc
            1:  w[6:0] = 7'b0110111;                                         // lui
            2:  w[6:0] = 7'b1101111;                                         // jal
            3:  {w[14:12], w[6:0]} = {3'd0, 7'b1100111};                     // jalr
            4:  {w[14:12], w[6:0]} = {3'd3, 7'b0100011};                     // sd
            5:  {w[14:12], w[6:0]} = {3'd2, 7'b0100011};
            6:  {w[14:12], w[6:0]} = {3'd0, 7'b0100011};
            7:  {w[14:12], w[6:0]} = {3'd3, 7'b0000011};                     // ld
            8:  {w[14:12], w[6:0]} = {3'd2, 7'b0000011};
            9:  {w[14:12], w[6:0]} = {3'd4, 7'b0000011};
            10: {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'd7, 7'b0110011};    // and
            11: {w[14:12], w[6:0]} = {3'd7, 7'b0010011};
            12: {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'd0, 7'b0110011};
            13: {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'd6, 7'b0110011};
            14: {w[14:12], w[6:0]} = {3'd4, 7'b0010011};                     // xori
            15: {w[31:25], w[14:12], w[6:0]} = {7'h01, 3'd0, 7'b0111011};    // mulw
            16: {w[31:25], w[14:12], w[6:0]} = {7'h01, 3'd4, 7'b0111011};
            17: {w[31:25], w[14:12], w[6:0]} = {7'h01, 3'd6, 7'b0111011};
            18: {w[14:12], w[6:0]} = {3'd0, 7'b0010011};                     // addi
            19: {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'd0, 7'b0111011};
            20: {w[14:12], w[6:0]} = {3'd0, 7'b0011011};                     // addiw
            21: {w[31:25], w[14:12], w[6:0]} = {7'h20, 3'd0, 7'b0110011};    // sub
            22: {w[14:12], w[6:0]} = {3'd3, 7'b0010011};
            23: {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'd3, 7'b0110011};    // sltu
            24: {w[31:26], w[14:12], w[6:0]} = {6'b010000, 3'd5, 7'b0010011}; // srai
            25: {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'd1, 7'b0111011};
            26: {w[31:26], w[14:12], w[6:0]} = {6'b000000, 3'd1, 7'b0010011}; // slli
            27: {w[31:26], w[14:12], w[6:0]} = {6'b000000, 3'd5, 7'b0010011};
            28: {w[14:12], w[6:0]} = {3'd1, 7'b1100011};                     // bne
            29: {w[14:12], w[6:0]} = {3'd0, 7'b1100011};
            30: {w[14:12], w[6:0]} = {3'd5, 7'b1100011};
            default: w = 32'h0010_0073;                                     // ebreak
        endcase
        return w;
    endfunction

    task automatic write_raw(logic [3:0] addr, logic [31:0] data, logic [3:0] strb,
                             logic [1:0] resp);
        @(posedge clk_i);
        awaddr_i  <= addr;
        wdata_i   <= data;
        wstrb_i   <= strb;
        awvalid_i <= 1'b1;
        wvalid_i  <= 1'b1;
        do @(posedge clk_i); while (!(awready_o && wready_o));
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        b_exp_q.push_back(resp);
        if (resp == `RV_RESP_OKAY) begin
            exp_q.push_back(rv_model_decode(data));
        end
    endtask

    task automatic write_inst(logic [31:0] w);
        write_raw(`RV_ADDR_INST, w, 4'hF, `RV_RESP_OKAY);
    endtask

    // expectation is taken at the AR handshake
    task automatic read_reg(logic [3:0] addr);
        rd_exp_t     e;
        dec_result_t r;
        @(posedge clk_i);
        araddr_i  <= addr;
        arvalid_i <= 1'b1;
        do @(posedge clk_i); while (!arready_o);
        arvalid_i <= 1'b0;
        e.addr = addr;
        e.resp = `RV_RESP_OKAY;
        e.data = '0;
        case (addr)
            `RV_ADDR_STATUS: e.data = (exp_q.size() < DEPTH) ? 32'(exp_q.size()) : 32'(DEPTH);
            `RV_ADDR_IMM: begin
                if (exp_q.size() > 0) e.data = exp_q[0].imm[31:0];
                else e.resp = `RV_RESP_SLVERR;
            end
            `RV_ADDR_CTRL: begin
                if (exp_q.size() > 0) begin
                    r      = exp_q.pop_front();
                    e.data = 32'(r.ctrl);
                end else begin
                    e.resp = `RV_RESP_SLVERR;
                end
            end
            default: e.resp = `RV_RESP_SLVERR;
        endcase
        rd_exp_q.push_back(e);
    endtask

    // lanes drain into the FIFO one per cycle
    task automatic settle();
        repeat (NL + 2) @(posedge clk_i);
    endtask

    task automatic drain(int n);
        repeat (n) begin
            read_reg(`RV_ADDR_IMM);
            read_reg(`RV_ADDR_CTRL);
        end
    endtask

    always @(posedge clk_i) begin : compare_proc
        rd_exp_t    e;
        logic [1:0] br;
        if (rvalid_o && rready_i) begin
            if (rd_exp_q.size() == 0) begin
                $display("read response arrived with no read outstanding");
                abort_run();
            end
            e = rd_exp_q.pop_front();
            check_resp("rresp", rresp_o, e.resp);
            case (e.addr)
                `RV_ADDR_CTRL:   check_ctrl("rdata ctrl", rdata_o, dec_ctrl_t'(e.data[27:0]));
                `RV_ADDR_STATUS: check_count("rdata status", rdata_o, e.data);
                default:         check_imm("rdata imm", rdata_o, e.data);
            endcase
        end
        if (bvalid_o && bready_i) begin
            if (b_exp_q.size() == 0) begin
                $display("write response arrived with no write outstanding");
                abort_run();
            end
            br = b_exp_q.pop_front();
            check_resp("bresp", bresp_o, br);
        end
    end

    initial begin : watchdog
        #(N_INST * 40 * CLK_PERIOD);
        $display("timeout, the tests did not finish in time");
        abort_run();
    end

    initial begin
        int          k;
        logic [31:0] w;
        dec_result_t r;
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // every kind once and then random kinds in bursts longer than the lane count
        for (k = 0; k < N_LEGAL; k++) begin
            write_inst(make_inst(k < 32 ? k : int'(take_bits(5))));
            if (k % BATCH == BATCH - 1) begin
                settle();
                drain(BATCH);
            end
        end

        for (k = 0; k < N_ILLEGAL; k++) begin
            do begin
                w = take_bits(32);
                r = rv_model_decode(w);
            end while (!r.ctrl.illegal);
            write_inst(w);
        end
        settle();
        drain(N_ILLEGAL);

        // fill lanes and FIFO so the next write stalls
        for (k = 0; k < NL + DEPTH; k++) begin
            write_inst(make_inst(int'(take_bits(5))));
        end
        settle();
        read_reg(`RV_ADDR_STATUS);
        fork
            begin
                write_inst(make_inst(int'(take_bits(5))));
                late_done = 1'b1;
            end
        join_none
        settle();
        if (late_done) begin
            $display("a write was accepted while all lanes and the FIFO were full");
            abort_run();
        end
        read_reg(`RV_ADDR_CTRL);
        wait (late_done);
        settle();
        drain(NL + DEPTH);

        // error responses around two waiting entries
        write_inst(make_inst(int'(take_bits(5))));
        write_inst(make_inst(int'(take_bits(5))));
        write_raw(`RV_ADDR_STATUS, take_bits(32), 4'hF, `RV_RESP_SLVERR);
        write_raw(`RV_ADDR_INST, take_bits(32), 4'h7, `RV_RESP_SLVERR);
        settle();
        read_reg(4'h1);
        read_reg(4'h6);
        read_reg(`RV_ADDR_STATUS);
        drain(2);
        read_reg(`RV_ADDR_IMM);
        read_reg(`RV_ADDR_CTRL);
        read_reg(`RV_ADDR_STATUS);

        for (k = 0; k < 3; k++) begin
            write_inst(make_inst(int'(take_bits(5))));
        end
        settle();
        read_reg(`RV_ADDR_STATUS);
        drain(3);
        settle();

        if (exp_q.size() != 0 || rd_exp_q.size() != 0 || b_exp_q.size() != 0) begin
            $display("responses still missing at the end of the run");
            abort_run();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// ==== rv_decode_cluster.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module rv_decode_cluster (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [3:0]  awaddr_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    output logic        bvalid_o,
    input  logic        bready_i,
    output logic [1:0]  bresp_o,
    input  logic        arvalid_i,
    output logic        arready_o,
    input  logic [3:0]  araddr_i,
    output logic        rvalid_o,
    input  logic        rready_i,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o
);
    import rv_decode_pkg::*;

    logic [`RV_NUM_LANES-1:0] lane_ready;
    logic [`RV_NUM_LANES-1:0] lane_valid;
    logic [31:0]              lane_inst;
    logic [`RV_NUM_LANES-1:0] res_valid;
    logic [`RV_NUM_LANES-1:0] take;
    dec_result_t              res [`RV_NUM_LANES];

    inst_dispatch inst_dispatch_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .awvalid_i    (awvalid_i),
        .awready_o    (awready_o),
        .awaddr_i     (awaddr_i),
        .wvalid_i     (wvalid_i),
        .wready_o     (wready_o),
        .wdata_i      (wdata_i),
        .wstrb_i      (wstrb_i),
        .bvalid_o     (bvalid_o),
        .bready_i     (bready_i),
        .bresp_o      (bresp_o),
        .lane_ready_i (lane_ready),
        .lane_valid_o (lane_valid),
        .lane_inst_o  (lane_inst)
    );

    for (genvar i = 0; i < `RV_NUM_LANES; i++) begin : g_lane
        inst_decode_lane inst_decode_lane_i (
            .clk_i        (clk_i),
            .arst_n_i     (arst_n_i),
            .inst_valid_i (lane_valid[i]),
            .inst_i       (lane_inst),
            .ready_o      (lane_ready[i]),
            .res_valid_o  (res_valid[i]),
            .res_o        (res[i]),
            .take_i       (take[i])
        );
    end

    decode_collect decode_collect_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .lane_res_valid_i (res_valid),
        .lane_res_i       (res),
        .lane_take_o      (take),
        .arvalid_i        (arvalid_i),
        .arready_o        (arready_o),
        .araddr_i         (araddr_i),
        .rvalid_o         (rvalid_o),
        .rready_i         (rready_i),
        .rdata_o          (rdata_o),
        .rresp_o          (rresp_o)
    );

endmodule

// ==== decode_collect.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module decode_collect (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic [`RV_NUM_LANES-1:0]   lane_res_valid_i,
    input  rv_decode_pkg::dec_result_t lane_res_i [`RV_NUM_LANES],
    output logic [`RV_NUM_LANES-1:0]   lane_take_o,
    input  logic                       arvalid_i,
    output logic                       arready_o,
    input  logic [3:0]                 araddr_i,
    output logic                       rvalid_o,
    input  logic                       rready_i,
    output logic [31:0]                rdata_o,
    output logic [1:0]                 rresp_o
);
    import rv_decode_pkg::*;

    localparam int NL    = `RV_NUM_LANES;
    localparam int DEPTH = `RV_FIFO_DEPTH;
    localparam int PW    = $clog2(NL);
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    logic [PW-1:0] rd_ptr_q;
    dec_result_t   fifo_q [DEPTH];
    logic [AW-1:0] head_q;
    logic [AW-1:0] tail_q;
    logic [CW-1:0] count_q;
    logic          empty;
    logic          push;
    logic          pop;
    logic          ar_hs;
    logic          rvalid_q;
    logic [31:0]   rdata_q;
    logic [1:0]    rresp_q;
    logic [31:0]   rdata_d;
    logic [1:0]    rresp_d;

    assign empty = (count_q == '0);
    assign push  = lane_res_valid_i[rd_ptr_q] && (count_q < CW'(DEPTH));  // next in order only
    assign ar_hs = arvalid_i && !rvalid_q;
    assign pop   = ar_hs && (araddr_i == `RV_ADDR_CTRL) && !empty;

    assign lane_take_o = push ? (NL'(1) << rd_ptr_q) : '0;
    assign arready_o   = ar_hs;
    assign rvalid_o    = rvalid_q;
    assign rdata_o     = rdata_q;
    assign rresp_o     = rresp_q;

    always_comb begin
        rdata_d = '0;
        rresp_d = `RV_RESP_SLVERR;
        case (araddr_i)
            `RV_ADDR_STATUS: begin
                rdata_d = 32'(count_q);
                rresp_d = `RV_RESP_OKAY;
            end
            `RV_ADDR_IMM: if (!empty) begin
                rdata_d = fifo_q[head_q].imm[31:0];  // peek only
                rresp_d = `RV_RESP_OKAY;
            end
            `RV_ADDR_CTRL: if (!empty) begin
                rdata_d = 32'(fifo_q[head_q].ctrl);
                rresp_d = `RV_RESP_OKAY;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_q <= '0;
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            rvalid_q <= 1'b0;
        end else begin
            if (push) begin
                rd_ptr_q <= (rd_ptr_q == PW'(NL - 1)) ? '0 : rd_ptr_q + 1'b1;
                tail_q   <= (tail_q == AW'(DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= (head_q == AW'(DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            count_q <= count_q + CW'(push) - CW'(pop);
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[tail_q] <= lane_res_i[rd_ptr_q];
        end
        if (ar_hs) begin
            rdata_q <= rdata_d;
            rresp_q <= rresp_d;
        end
    end

endmodule

// ==== inst_decode_lane.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module inst_decode_lane (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       inst_valid_i,
    input  logic [31:0]                inst_i,
    output logic                       ready_o,
    output logic                       res_valid_o,
    output rv_decode_pkg::dec_result_t res_o,
    input  logic                       take_i
);
    import rv_decode_pkg::*;

    dec_ctrl_t   cd;
    logic [63:0] imm_d;
    dec_result_t res_q;
    logic        valid_q;

    function automatic dec_ctrl_t ctl(imm_sel_e imm, alu_op_e op, a_sel_e a, b_sel_e b,
                                      logic wen, pc_sel_e pc, wb_sel_e wb,
                                      logic mw, logic mr);
        dec_ctrl_t c;
        c         = '0;
        c.imm_sel = imm;
        c.op.alu  = op;
        c.a_sel   = a;
        c.b_sel   = b;
        c.reg_wen = wen;
        c.pc_sel  = pc;
        c.wb_sel  = wb;
        c.mem_wen = mw;
        c.mem_ren = mr;
        return c;
    endfunction

    // branches compare rs1/rs2, no writeback
    function automatic dec_ctrl_t br_ctl(branch_op_e op);
        dec_ctrl_t c;
        c         = '0;
        c.imm_sel = imm_b;
        c.op.br   = op;
        c.pc_sel  = pc_branch;
        return c;
    endfunction

    always_comb begin
        casez (inst_i)
            `I_AUIPC: cd = ctl(imm_u, alu_add, a_pc, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_LUI: cd = ctl(imm_u, alu_add, a_zero, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_JAL: cd = ctl(imm_j, alu_add, a_pc, b_imm, 1'b1, pc_alu, wb_pc4, 1'b0, 1'b0);
            `I_JALR: cd = ctl(imm_i, alu_add, a_reg, b_imm, 1'b1, pc_alu, wb_pc4, 1'b0, 1'b0);
            `I_SD: cd = ctl(imm_s, alu_add, a_reg, b_imm, 1'b0, pc_4, wb_alu, 1'b1, 1'b0);
            `I_SW: cd = ctl(imm_s, alu_add, a_reg, b_imm, 1'b0, pc_4, wb_alu, 1'b1, 1'b0);
            `I_SB: cd = ctl(imm_s, alu_add, a_reg, b_imm, 1'b0, pc_4, wb_alu, 1'b1, 1'b0);
            `I_LD: cd = ctl(imm_i, alu_add, a_reg, b_imm, 1'b1, pc_4, wb_mem, 1'b0, 1'b1);
            `I_LW: cd = ctl(imm_i, alu_add, a_reg, b_imm, 1'b1, pc_4, wb_mem, 1'b0, 1'b1);
            `I_LBU: cd = ctl(imm_i, alu_add, a_reg, b_imm, 1'b1, pc_4, wb_mem, 1'b0, 1'b1);
            `I_AND: cd = ctl(imm_none, alu_and, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_ANDI: cd = ctl(imm_i, alu_and, a_reg, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_ADD: cd = ctl(imm_none, alu_add, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_OR: cd = ctl(imm_none, alu_or, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_XORI: cd = ctl(imm_i, alu_xor, a_reg, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_MULW: cd = ctl(imm_none, alu_mulw, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_DIVW: cd = ctl(imm_none, alu_divw, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_REMW: cd = ctl(imm_none, alu_remw, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_ADDI: cd = ctl(imm_i, alu_add, a_reg, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_ADDW: cd = ctl(imm_none, alu_addw, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_ADDIW: cd = ctl(imm_i, alu_addw, a_reg, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_SUB: cd = ctl(imm_none, alu_sub, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_SLTIU: cd = ctl(imm_i, alu_sltu, a_reg, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_SLTU: cd = ctl(imm_none, alu_sltu, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_SRAI: cd = ctl(imm_i, alu_sra, a_reg, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_SLLW: cd = ctl(imm_none, alu_sllw, a_reg, b_reg, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_SLLI: cd = ctl(imm_i, alu_sll, a_reg, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_SRLI: cd = ctl(imm_i, alu_srl, a_reg, b_imm, 1'b1, pc_4, wb_alu, 1'b0, 1'b0);
            `I_BNE: cd = br_ctl(br_bne);
            `I_BEQ: cd = br_ctl(br_beq);
            `I_BGE: cd = br_ctl(br_bge);
            `I_EBREAK: cd = '0;  // legal, no side effects
            default: begin
                cd         = '0;
                cd.illegal = 1'b1;
            end
        endcase
        cd.func3 = inst_i[14:12];
        cd.rd    = inst_i[11:7];
    end

    // all formats sign-extend from bit 31
    always_comb begin
        case (cd.imm_sel)
            imm_i:   imm_d = {{52{inst_i[31]}}, inst_i[31:20]};
            imm_s:   imm_d = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            imm_b:   imm_d = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            imm_u:   imm_d = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
            imm_j:   imm_d = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            default: imm_d = '0;
        endcase
    end

    assign ready_o     = !valid_q || take_i;
    assign res_valid_o = valid_q;
    assign res_o       = res_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (inst_valid_i && ready_o) begin
            valid_q <= 1'b1;
        end else if (take_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_valid_i && ready_o) begin
            res_q.ctrl <= cd;
            res_q.imm  <= imm_d;
        end
    end

endmodule

// ==== inst_dispatch.sv ====
`timescale 1ns/1ps
`include "rv_decode_defines.svh"

module inst_dispatch (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     awvalid_i,
    output logic                     awready_o,
    input  logic [3:0]               awaddr_i,
    input  logic                     wvalid_i,
    output logic                     wready_o,
    input  logic [31:0]              wdata_i,
    input  logic [3:0]               wstrb_i,
    output logic                     bvalid_o,
    input  logic                     bready_i,
    output logic [1:0]               bresp_o,
    input  logic [`RV_NUM_LANES-1:0] lane_ready_i,
    output logic [`RV_NUM_LANES-1:0] lane_valid_o,
    output logic [31:0]              lane_inst_o
);
    localparam int NL = `RV_NUM_LANES;
    localparam int PW = $clog2(NL);

    logic [PW-1:0] wr_ptr_q;
    logic          bvalid_q;
    logic [1:0]    bresp_q;
    logic          inst_ok;
    logic          wr_hs;

    // only full-word writes to INST reach a lane
    assign inst_ok = (awaddr_i == `RV_ADDR_INST) && (&wstrb_i);

    // bad writes need no lane, they are dropped
    assign wr_hs = awvalid_i && wvalid_i && !bvalid_q && (!inst_ok || lane_ready_i[wr_ptr_q]);

    assign awready_o    = wr_hs;
    assign wready_o     = wr_hs;
    assign lane_inst_o  = wdata_i;
    assign lane_valid_o = (wr_hs && inst_ok) ? (NL'(1) << wr_ptr_q) : '0;
    assign bvalid_o     = bvalid_q;
    assign bresp_o      = bresp_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            bvalid_q <= 1'b0;
        end else begin
            if (wr_hs && inst_ok) begin
                wr_ptr_q <= (wr_ptr_q == PW'(NL - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            bresp_q <= inst_ok ? `RV_RESP_OKAY : `RV_RESP_SLVERR;
        end
    end

endmodule

// ==== rv_decode_pkg.sv ====
package rv_decode_pkg;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_sel_e;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_addw,
        alu_sllw,
        alu_mulw,
        alu_divw,
        alu_remw
    } alu_op_e;

    typedef enum logic [4:0] {
        br_beq,
        br_bne,
        br_bge
    } branch_op_e;

    // branch view valid when pc_sel is pc_branch
    typedef union packed {
        alu_op_e    alu;
        branch_op_e br;
    } op_u;

    typedef enum logic [1:0] {a_reg, a_pc, a_zero} a_sel_e;
    typedef enum logic [1:0] {b_reg, b_imm} b_sel_e;
    typedef enum logic [1:0] {pc_4, pc_alu, pc_branch} pc_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_pc4, wb_mem} wb_sel_e;

    typedef struct packed {
        logic       illegal;
        imm_sel_e   imm_sel;
        op_u        op;
        a_sel_e     a_sel;
        b_sel_e     b_sel;
        logic       reg_wen;
        pc_sel_e    pc_sel;
        wb_sel_e    wb_sel;
        logic       mem_wen;
        logic       mem_ren;
        logic [2:0] func3;
        logic [4:0] rd;
    } dec_ctrl_t;

    typedef struct packed {
        dec_ctrl_t   ctrl;
        logic [63:0] imm;
    } dec_result_t;

endpackage

// ==== rv_decode_defines.svh ====
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

`define RV_NUM_LANES        4
`define RV_FIFO_DEPTH       4

// register map, byte addresses
`define RV_ADDR_INST        4'h0
`define RV_ADDR_STATUS      4'h4
`define RV_ADDR_IMM         4'h8
`define RV_ADDR_CTRL        4'hC

`define RV_RESP_OKAY        2'b00
`define RV_RESP_SLVERR      2'b10

// match patterns: funct7 rs2 rs1 funct3 rd opcode
`define I_AUIPC     32'b???????_?????_?????_???_?????_0010111
`define I_LUI       32'b???????_?????_?????_???_?????_0110111
`define I_JAL       32'b???????_?????_?????_???_?????_1101111
`define I_JALR      32'b???????_?????_?????_000_?????_1100111
`define I_SD        32'b???????_?????_?????_011_?????_0100011
`define I_SW        32'b???????_?????_?????_010_?????_0100011
`define I_SB        32'b???????_?????_?????_000_?????_0100011
`define I_LD        32'b???????_?????_?????_011_?????_0000011
`define I_LW        32'b???????_?????_?????_010_?????_0000011
`define I_LBU       32'b???????_?????_?????_100_?????_0000011
`define I_AND       32'b0000000_?????_?????_111_?????_0110011
`define I_ANDI      32'b???????_?????_?????_111_?????_0010011
`define I_ADD       32'b0000000_?????_?????_000_?????_0110011
`define I_OR        32'b0000000_?????_?????_110_?????_0110011
`define I_XORI      32'b???????_?????_?????_100_?????_0010011
`define I_MULW      32'b0000001_?????_?????_000_?????_0111011
`define I_DIVW      32'b0000001_?????_?????_100_?????_0111011
`define I_REMW      32'b0000001_?????_?????_110_?????_0111011
`define I_ADDI      32'b???????_?????_?????_000_?????_0010011
`define I_ADDW      32'b0000000_?????_?????_000_?????_0111011
`define I_ADDIW     32'b???????_?????_?????_000_?????_0011011
`define I_SUB       32'b0100000_?????_?????_000_?????_0110011
`define I_SLTIU     32'b???????_?????_?????_011_?????_0010011
`define I_SLTU      32'b0000000_?????_?????_011_?????_0110011
`define I_SRAI      32'b010000?_?????_?????_101_?????_0010011
`define I_SLLW      32'b0000000_?????_?????_001_?????_0111011
`define I_SLLI      32'b000000?_?????_?????_001_?????_0010011
`define I_SRLI      32'b000000?_?????_?????_101_?????_0010011
`define I_BNE       32'b???????_?????_?????_001_?????_1100011
`define I_BEQ       32'b???????_?????_?????_000_?????_1100011
`define I_BGE       32'b???????_?????_?????_101_?????_1100011
`define I_EBREAK    32'b0000000_00001_00000_000_00000_1110011

`endif
